/* hw/cam_cfg_pkg.sv */
package cam_cfg_pkg;

   // bus addressing, 8-bit write form
   typedef logic [7:0]  slave_addr_t;   // addr in [7:1], r/w slot in [0]
   typedef logic [15:0] reg_addr_t;     // sensor register pointer
   typedef logic [7:0]  reg_data_t;     // register value or id byte

   // script walk
   typedef logic [4:0]  script_idx_t;

   // one script line: either a register write or a timed pause
   typedef struct packed {
      slave_addr_t slave;   // DELAY_MARK here means pause
      reg_addr_t   addr;    // ignored for a pause
      reg_data_t   data;    // value, or tick count for a pause
   } script_entry_t;

   // sensor identity
   localparam slave_addr_t SENSOR_ADDR = 8'h6c;
   localparam reg_addr_t   ID_POINTER  = 16'h300b;
   localparam reg_data_t   ID_EXPECTED = 8'h88;

   // script layout
   localparam slave_addr_t DELAY_MARK = 8'hAA;   // not a legal sensor address
   localparam int          SCRIPT_LEN = 20;

   // timing in CLK_400K cycles
   localparam int DELAY_TICK_CYCLES = 16;   // per count of a pause entry
   localparam int RETRY_GAP_CYCLES  = 6;    // bus rest before id retry

endpackage

/* hw/i2c_pkg.sv */
package i2c_pkg;

   import cam_cfg_pkg::*;

   typedef enum logic [1:0] {
      OP_WRITE,     // 16-bit pointer, 8-bit data
      OP_READ_ID,   // pointer write, stop, one-byte read
      OP_DELAY      // idle bus for data ticks
   } i2c_op_e;

   // queued command, consumed whole by the bit engine
   typedef struct packed {
      i2c_op_e     op;
      slave_addr_t slave;
      reg_addr_t   addr;
      reg_data_t   data;
   } i2c_cmd_t;

   typedef struct packed {
      logic      done;    // one-cycle pulse at end of an id read
      logic      nack;    // some byte went unacknowledged
      reg_data_t rdata;   // last byte read
   } i2c_result_t;

   localparam int QUARTERS_PER_BIT = 4;   // scl bit time in clocks
   localparam int FIFO_DEPTH       = 4;

endpackage

/* hw/sensor_script_rom.sv */
module sensor_script_rom
   import cam_cfg_pkg::*;
(
   input  script_idx_t   idx,
   output script_entry_t entry
);

   always_comb begin
      case (idx)
         5'd0:    entry = {SENSOR_ADDR, 16'h0103, 8'h01};   // soft reset
         5'd1:    entry = {SENSOR_ADDR, 16'h0103, 8'h01};   // issued twice
         5'd2:    entry = {DELAY_MARK,  16'h0000, 8'd10};   // reset settle
         5'd3:    entry = {SENSOR_ADDR, 16'h0100, 8'h00};   // standby
         5'd4:    entry = {SENSOR_ADDR, 16'h0100, 8'h00};
         // pll setup
         5'd5:    entry = {SENSOR_ADDR, 16'h0302, 8'h18};   // pll1 mult
         5'd6:    entry = {SENSOR_ADDR, 16'h0303, 8'h00};   // pll1 pre-div
         5'd7:    entry = {SENSOR_ADDR, 16'h0304, 8'h03};   // mipi div
         5'd8:    entry = {SENSOR_ADDR, 16'h3018, 8'h72};   // 4 mipi lanes
         5'd9:    entry = {SENSOR_ADDR, 16'h3641, 8'h55};   // mipi phy
         5'd10:   entry = {SENSOR_ADDR, 16'h3646, 8'h86};
         // output window 640x480
         5'd11:   entry = {SENSOR_ADDR, 16'h3808, 8'h02};   // width hi
         5'd12:   entry = {SENSOR_ADDR, 16'h3809, 8'h80};   // width lo
         5'd13:   entry = {SENSOR_ADDR, 16'h380a, 8'h01};   // height hi
         5'd14:   entry = {SENSOR_ADDR, 16'h380b, 8'he0};   // height lo
         5'd15:   entry = {DELAY_MARK,  16'h0000, 8'd10};
         5'd16:   entry = {SENSOR_ADDR, 16'h5018, 8'h19};   // mwb red
         5'd17:   entry = {SENSOR_ADDR, 16'h501a, 8'h10};   // mwb green
         5'd18:   entry = {SENSOR_ADDR, 16'h501c, 8'h17};   // mwb blue
         5'd19:   entry = {SENSOR_ADDR, 16'h0100, 8'h01};   // start streaming
         default: entry = {DELAY_MARK,  16'h0000, 8'd0};    // past end, harmless
      endcase
   end

endmodule

/* hw/cfg_sequencer.sv */
module cfg_sequencer
   import cam_cfg_pkg::*, i2c_pkg::*;
(
   input  logic          CLK_400K,
   input  logic          RESET_N,
   output script_idx_t   idx,
   input  script_entry_t entry,
   output logic          push,
   output i2c_cmd_t      push_cmd,
   input  logic          full,
   input  logic          empty,
   input  logic          busy,
   input  i2c_result_t   result,
   output logic          cam_released
);

   typedef enum logic [2:0] {
      ID_ISSUE,
      ID_WAIT,
      RETRY_GAP,
      SCRIPT,
      DRAIN,
      RELEASED
   } seq_state_e;

   localparam int GAP_W = $clog2(RETRY_GAP_CYCLES);

   seq_state_e       state;
   logic [GAP_W-1:0] gap_cnt;
   i2c_cmd_t         id_cmd;
   i2c_cmd_t         script_cmd;
   logic             id_ok;

   assign id_cmd = '{op: OP_READ_ID, slave: SENSOR_ADDR, addr: ID_POINTER, data: '0};

   // rom entry to bus command
   always_comb begin
      script_cmd.slave = entry.slave;
      script_cmd.addr  = entry.addr;
      script_cmd.data  = entry.data;
      if (entry.slave == DELAY_MARK) begin
         script_cmd.op = OP_DELAY;
      end else begin
         script_cmd.op = OP_WRITE;
      end
   end

   assign push         = ((state == ID_ISSUE) || (state == SCRIPT)) && !full;
   assign push_cmd     = (state == SCRIPT) ? script_cmd : id_cmd;
   assign id_ok        = !result.nack && (result.rdata == ID_EXPECTED);
   assign cam_released = (state == RELEASED);

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state   <= ID_ISSUE;
         idx     <= '0;
         gap_cnt <= '0;
      end else begin
         case (state)
            ID_ISSUE: begin
               if (push) state <= ID_WAIT;
            end
            ID_WAIT: begin
               if (result.done) begin
                  if (id_ok) begin
                     state <= SCRIPT;
                     idx   <= '0;
                  end else begin
                     state   <= RETRY_GAP;   // nack or wrong part
                     gap_cnt <= '0;
                  end
               end
            end
            RETRY_GAP: begin
               if (gap_cnt == GAP_W'(RETRY_GAP_CYCLES - 1)) begin
                  state <= ID_ISSUE;
               end else begin
                  gap_cnt <= gap_cnt + 1'b1;
               end
            end
            SCRIPT: begin
               // idx only moves on an accepted push
               if (push) begin
                  if (idx == script_idx_t'(SCRIPT_LEN - 1)) begin
                     state <= DRAIN;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            DRAIN: begin
               if (empty && !busy) state <= RELEASED;   // last stop is out
            end
            RELEASED: begin
               state <= RELEASED;
            end
            default: state <= ID_ISSUE;
         endcase
      end
   end

   a_release_sticky: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      cam_released |=> cam_released);

endmodule

/* hw/cmd_fifo.sv */
module cmd_fifo
   import i2c_pkg::*;
(
   input  logic     CLK_400K,
   input  logic     RESET_N,
   input  logic     push,
   input  i2c_cmd_t push_cmd,
   input  logic     pop,
   output i2c_cmd_t pop_cmd,
   output logic     full,
   output logic     empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   i2c_cmd_t         mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             wr_en;
   logic             rd_en;

   assign wr_en   = push && !full;
   assign rd_en   = pop && !empty;
   assign full    = (count == CNT_W'(FIFO_DEPTH));
   assign empty   = (count == '0);
   assign pop_cmd = mem[rd_ptr];   // head shown without a cycle of delay

   always_ff @(posedge CLK_400K) begin
      if (wr_en) mem[wr_ptr] <= push_cmd;
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_pop_empty: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      pop |-> !empty);

   a_no_push_full: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      push |-> !full);

endmodule

/* hw/i2c_master.sv */
module i2c_master
   import cam_cfg_pkg::*, i2c_pkg::*;
(
   input  logic        CLK_400K,
   input  logic        RESET_N,
   input  logic        empty,
   output logic        pop,
   input  i2c_cmd_t    pop_cmd,
   output logic        busy,
   output i2c_result_t result,
   output logic        scl_drive_low,
   output logic        sda_drive_low,
   input  logic        sda_in
);

   typedef enum logic [2:0] {IDLE, START, SHIFT, ACK, STOP, RESTART, READ, WAIT} phase_e;

   localparam int             Q_W      = $clog2(QUARTERS_PER_BIT);
   localparam int             DLY_W    = $bits(reg_data_t) + $clog2(DELAY_TICK_CYCLES);
   localparam logic [Q_W-1:0] Q_LAST   = Q_W'(QUARTERS_PER_BIT - 1);
   localparam logic [Q_W-1:0] Q_SAMPLE = Q_W'(QUARTERS_PER_BIT / 2);   // scl high here

   phase_e           phase;
   logic [Q_W-1:0]   q;
   logic [2:0]       bit_cnt;
   logic [1:0]       byte_cnt;
   logic [1:0]       next_cnt;
   logic             rd_half;     // second frame of an id read
   reg_data_t        shreg;
   reg_data_t        rdata_q;
   i2c_cmd_t         cmd;
   logic [DLY_W-1:0] delay_cnt;
   logic             nack_q;
   logic             done_q;
   logic             bit_end;
   logic             last_byte;
   logic             mst_ack;
   logic             load_byte;

   // byte n of the current frame
   function automatic reg_data_t tx_byte(input i2c_cmd_t c, input logic [1:0] n,
                                         input logic rd);
      reg_data_t b;
      case (n)
         2'd0:    b = rd ? (c.slave | 8'h01) : c.slave;
         2'd1:    b = c.addr[15:8];
         2'd2:    b = c.addr[7:0];
         default: b = c.data;
      endcase
      return b;
   endfunction

   assign bit_end   = (q == Q_LAST);
   assign last_byte = (cmd.op == OP_WRITE) ? (byte_cnt == 2'd3) : (byte_cnt == 2'd2);
   assign mst_ack   = rd_half && (byte_cnt == 2'd1);   // after the read data byte
   assign next_cnt  = (phase == ACK) ? byte_cnt + 2'd1 : byte_cnt;
   assign load_byte = bit_end && ((phase == START) || (phase == RESTART) ||
                                  ((phase == ACK) && !rd_half && !last_byte));

   assign pop    = (phase == IDLE) && !empty;
   assign busy   = (phase != IDLE);
   assign result = '{done: done_q, nack: nack_q, rdata: rdata_q};

   // pin waveform per quarter
   always_comb begin
      scl_drive_low = 1'b0;
      sda_drive_low = 1'b0;
      case (phase)
         START, RESTART: begin
            scl_drive_low = (q == Q_LAST);
            sda_drive_low = (q != '0);   // sda falls with scl high
         end
         SHIFT: begin
            scl_drive_low = (q == '0) || (q == Q_LAST);
            sda_drive_low = !shreg[7];   // msb first
         end
         ACK, READ: begin
            scl_drive_low = (q == '0) || (q == Q_LAST);
         end
         STOP: begin
            scl_drive_low = (q == '0);
            sda_drive_low = (q < Q_SAMPLE);   // sda rises with scl high
         end
         default: begin
            scl_drive_low = 1'b0;
            sda_drive_low = 1'b0;
         end
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (pop) cmd <= pop_cmd;
      if (load_byte) begin
         shreg <= tx_byte(cmd, next_cnt, rd_half);
      end else if ((phase == SHIFT) && bit_end) begin
         shreg <= {shreg[6:0], 1'b0};
      end
      if ((phase == READ) && (q == Q_SAMPLE)) rdata_q <= {rdata_q[6:0], sda_in};
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         phase     <= IDLE;
         q         <= '0;
         bit_cnt   <= '0;
         byte_cnt  <= '0;
         rd_half   <= 1'b0;
         delay_cnt <= '0;
         nack_q    <= 1'b0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if ((phase != IDLE) && (phase != WAIT)) q <= q + 1'b1;   // wraps each bit
         case (phase)
            IDLE: begin
               if (pop) begin
                  nack_q   <= 1'b0;
                  byte_cnt <= '0;
                  rd_half  <= 1'b0;
                  if (pop_cmd.op == OP_DELAY) begin
                     delay_cnt <= DLY_W'(pop_cmd.data) * DLY_W'(DELAY_TICK_CYCLES);
                     phase     <= WAIT;
                  end else begin
                     phase <= START;
                  end
               end
            end
            WAIT: begin
               if (delay_cnt <= DLY_W'(1)) begin
                  phase <= IDLE;
               end else begin
                  delay_cnt <= delay_cnt - 1'b1;
               end
            end
            START, RESTART: begin
               if (bit_end) begin
                  bit_cnt <= 3'd7;
                  phase   <= SHIFT;
               end
            end
            SHIFT: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd0) phase <= ACK;
                  else bit_cnt <= bit_cnt - 1'b1;
               end
            end
            READ: begin
               if (bit_end) begin
                  if (bit_cnt == 3'd0) begin
                     byte_cnt <= 2'd1;
                     phase    <= ACK;   // master nacks the single byte
                  end else begin
                     bit_cnt <= bit_cnt - 1'b1;
                  end
               end
            end
            ACK: begin
               if ((q == Q_SAMPLE) && !mst_ack && sda_in) nack_q <= 1'b1;
               if (bit_end) begin
                  if (mst_ack || (!rd_half && last_byte)) begin
                     phase <= STOP;
                  end else if (rd_half) begin
                     bit_cnt <= 3'd7;
                     phase   <= READ;
                  end else begin
                     byte_cnt <= next_cnt;
                     bit_cnt  <= 3'd7;
                     phase    <= SHIFT;
                  end
               end
            end
            STOP: begin
               if (bit_end) begin
                  if ((cmd.op == OP_READ_ID) && !rd_half) begin
                     rd_half  <= 1'b1;   // pointer set, now the read frame
                     byte_cnt <= '0;
                     phase    <= RESTART;
                  end else begin
                     done_q <= (cmd.op == OP_READ_ID);
                     phase  <= IDLE;
                  end
               end
            end
            default: phase <= IDLE;
         endcase
      end
   end

   // data may only move while scl is low
   a_sda_stable: assert property (@(posedge CLK_400K) disable iff (!RESET_N)
      (!scl_drive_low && $past(!scl_drive_low) && $changed(sda_drive_low))
         |-> (phase inside {START, RESTART, STOP}));

endmodule

/* hw/camera_config_top.sv */
module camera_config_top
   import cam_cfg_pkg::*, i2c_pkg::*;
(
   input  logic CLK_400K,
   input  logic RESET_N,
   output logic i2c_scl,
   inout  wire  i2c_sda,
   output logic cam_released
);

   script_idx_t   idx;
   script_entry_t entry;
   logic          push;
   logic          pop;
   logic          full;
   logic          empty;
   logic          busy;
   i2c_cmd_t      push_cmd;
   i2c_cmd_t      pop_cmd;
   i2c_result_t   result;
   logic          scl_drive_low;
   logic          sda_drive_low;
   logic          sda_in;

   cfg_sequencer u_seq (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .idx          (idx),
      .entry        (entry),
      .push         (push),
      .push_cmd     (push_cmd),
      .full         (full),
      .empty        (empty),
      .busy         (busy),
      .result       (result),
      .cam_released (cam_released)
   );

   sensor_script_rom u_rom (
      .idx   (idx),
      .entry (entry)
   );

   cmd_fifo u_fifo (
      .CLK_400K (CLK_400K),
      .RESET_N  (RESET_N),
      .push     (push),
      .push_cmd (push_cmd),
      .pop      (pop),
      .pop_cmd  (pop_cmd),
      .full     (full),
      .empty    (empty)
   );

   i2c_master u_i2c (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .empty         (empty),
      .pop           (pop),
      .pop_cmd       (pop_cmd),
      .busy          (busy),
      .result        (result),
      .scl_drive_low (scl_drive_low),
      .sda_drive_low (sda_drive_low),
      .sda_in        (sda_in)
   );

   assign i2c_scl = !scl_drive_low;                 // low or released high
   assign i2c_sda = sda_drive_low ? 1'b0 : 1'bz;    // open drain
   assign sda_in  = i2c_sda;

endmodule

/* tb/i2c_sensor_model.sv */
module i2c_sensor_model
   import cam_cfg_pkg::*;
(
   input  logic        scl,
   inout  wire         sda,
   input  logic        clear,       // wipes the log between runs
   input  logic [3:0]  nack_n,      // id attempts whose pointer frame gets a nack
   input  logic [3:0]  wrong_n,     // id attempts answered with a wrong byte
   input  logic [63:0] wrong_ids
);

   logic        sda_low;
   logic        active;
   logic        first_fall;
   logic        tx;
   logic        rd_mode;
   logic        addressed;
   logic        next_low;
   int          bitn;
   int          byte_idx;
   int          attempt;
   reg_data_t   shift;
   reg_data_t   tx_byte;
   reg_data_t   fb [4];
   reg_data_t   first_bytes [3];
   reg_data_t   read_slave;
   int          frames;
   int          id_reads;
   int          n_writes;
   slave_addr_t w_slave [32];
   reg_addr_t   w_addr [32];
   reg_data_t   w_data [32];
   time         w_start [32];
   time         w_stop [32];
   time         frame_start;
   time         last_read_stop;

   assign sda = sda_low ? 1'b0 : 1'bz;

   initial begin
      sda_low = 1'b0;
      active  = 1'b0;
   end

   always @(posedge clear) begin
      sda_low        = 1'b0;
      active         = 1'b0;
      tx             = 1'b0;
      frames         = 0;
      id_reads       = 0;
      n_writes       = 0;
      last_read_stop = 0;
      read_slave     = '0;
      for (int i = 0; i < 3; i++) first_bytes[i] = '0;
   end

   // start: sda falls with scl high
   always @(negedge sda) begin
      if (scl === 1'b1) begin
         active      = 1'b1;
         first_fall  = 1'b1;
         bitn        = 0;
         byte_idx    = 0;
         tx          = 1'b0;
         rd_mode     = 1'b0;
         addressed   = 1'b0;
         frames      = frames + 1;
         frame_start = $time;
      end
   end

   // stop: sda rises with scl high
   always @(posedge sda) begin
      if ((scl === 1'b1) && active) begin
         if (addressed && !rd_mode && (byte_idx == 4) && (n_writes < 32)) begin
            w_slave[n_writes] = fb[0];
            w_addr[n_writes]  = {fb[1], fb[2]};
            w_data[n_writes]  = fb[3];
            w_start[n_writes] = frame_start;
            w_stop[n_writes]  = $time;
            n_writes          = n_writes + 1;
         end
         if (rd_mode) last_read_stop = $time;
         active = 1'b0;
      end
   end

   always @(posedge scl) begin
      if (active && !tx && (bitn < 8)) shift = {shift[6:0], (sda !== 1'b0)};
   end

   always @(negedge scl) begin
      if (active && !clear) begin
         next_low = 1'b0;
         if (first_fall) begin
            first_fall = 1'b0;   // fall that ends the start bit
            next_low   = sda_low;
         end else if (bitn < 8) begin
            bitn = bitn + 1;
            if ((bitn == 8) && !tx) begin
               if (byte_idx < 4) fb[byte_idx] = shift;
               if ((frames == 1) && (byte_idx < 3)) first_bytes[byte_idx] = shift;
               if (byte_idx == 0) begin
                  addressed = (shift[7:1] == SENSOR_ADDR[7:1]);
                  rd_mode   = shift[0];
                  if (rd_mode && addressed) begin
                     read_slave = shift;
                     attempt    = id_reads;
                     if ((attempt >= nack_n) && (attempt < nack_n + wrong_n)) begin
                        tx_byte = wrong_ids[(attempt - nack_n) * 8 +: 8];
                     end else begin
                        tx_byte = ID_EXPECTED;
                     end
                     id_reads = id_reads + 1;
                  end
                  next_low = addressed && !(!rd_mode && (id_reads < nack_n));
               end else begin
                  next_low = addressed;
               end
            end else if (tx && (bitn < 8)) begin
               next_low = !tx_byte[7 - bitn];
            end
         end else begin
            bitn     = 0;   // ack clock done
            byte_idx = byte_idx + 1;
            if (tx) begin
               tx = 1'b0;
            end else if (rd_mode && addressed && (byte_idx == 1)) begin
               tx       = 1'b1;
               next_low = !tx_byte[7];
            end
         end
         #1 sda_low = next_low;
      end
   end

endmodule

/* tb/tb_camera_config.sv */
module tb_camera_config
   import cam_cfg_pkg::*;
();

   localparam int  ROWS        = 4;
   localparam int  N_WR        = 18;
   localparam time CLK_PERIOD  = 40;
   localparam int  DELAY_COUNT = 10;      // count of both pause entries
   localparam int  REL_LIMIT   = 30000;   // cycles allowed to reach release
   localparam int  HOLD_CYCLES = 2000;

   logic        CLK_400K;
   logic        RESET_N;
   logic        clear;
   logic [3:0]  nack_n;
   logic [3:0]  wrong_n;
   logic [63:0] wrong_ids;
   wire         scl;
   wire         sda;
   wire         cam_released;

   int          seed;
   int          value_errs;
   int          timeout_errs;
   int          frames_at_rel;
   time         release_time;
   logic        released_ok;
   reg_data_t   rnd;

   // nack attempts, wrong-id attempts, expected id reads
   int nack_tab  [ROWS] = '{0, 2, 0, 1};
   int wrong_tab [ROWS] = '{0, 0, 3, 2};
   int reads_tab [ROWS] = '{1, 3, 4, 4};

   reg_addr_t exp_addr [N_WR] = '{16'h0103, 16'h0103, 16'h0100, 16'h0100, 16'h0302,
                                  16'h0303, 16'h0304, 16'h3018, 16'h3641, 16'h3646,
                                  16'h3808, 16'h3809, 16'h380a, 16'h380b, 16'h5018,
                                  16'h501a, 16'h501c, 16'h0100};
   reg_data_t exp_data [N_WR] = '{8'h01, 8'h01, 8'h00, 8'h00, 8'h18, 8'h00, 8'h03, 8'h72,
                                  8'h55, 8'h86, 8'h02, 8'h80, 8'h01, 8'he0, 8'h19, 8'h10,
                                  8'h17, 8'h01};

   pullup (scl);
   pullup (sda);

   camera_config_top u_dut (
      .CLK_400K     (CLK_400K),
      .RESET_N      (RESET_N),
      .i2c_scl      (scl),
      .i2c_sda      (sda),
      .cam_released (cam_released)
   );

   i2c_sensor_model u_model (
      .scl       (scl),
      .sda       (sda),
      .clear     (clear),
      .nack_n    (nack_n),
      .wrong_n   (wrong_n),
      .wrong_ids (wrong_ids)
   );

   initial begin
      CLK_400K = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_400K = ~CLK_400K;
   end

   task automatic check_byte(input string name, input reg_data_t got, input reg_data_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %02h expected %02h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %04h expected %04h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_level(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic apply_reset();
      @(posedge CLK_400K);
      #2;
      RESET_N = 1'b0;
      clear   = 1'b1;
      repeat (5) @(posedge CLK_400K);
      #2;
      RESET_N = 1'b1;
      clear   = 1'b0;
   endtask

   task automatic wait_release(input int row);
      int cycles;
      cycles      = 0;
      released_ok = 1'b0;
      while (!released_ok && (cycles < REL_LIMIT)) begin
         @(posedge CLK_400K);
         #2;
         cycles++;
         if (cam_released === 1'b1) begin
            released_ok  = 1'b1;
            release_time = $time;
         end
      end
      if (!released_ok) begin
         $display("timeout in row %0d, cam_released never rose", row);
         timeout_errs++;
      end
   endtask

   task automatic check_gap(input int after_wr);
      time gap;
      gap = u_model.w_start[after_wr + 1] - u_model.w_stop[after_wr];
      if (gap < DELAY_COUNT * DELAY_TICK_CYCLES * CLK_PERIOD) begin
         $display("bus idle after write %0d lasted only %0t", after_wr, gap);
         value_errs++;
      end
   endtask

   task automatic check_script();
      int n;
      n = u_model.n_writes;
      check_count("write count", n, N_WR);
      for (int i = 0; i < N_WR && i < n; i++) begin
         check_byte("write slave", u_model.w_slave[i], SENSOR_ADDR);
         check_addr("write addr", u_model.w_addr[i], exp_addr[i]);
         check_byte("write data", u_model.w_data[i], exp_data[i]);
      end
      if (n >= N_WR) begin
         check_gap(1);    // reset settle
         check_gap(13);   // after window size
         if (u_model.w_start[0] <= u_model.last_read_stop) begin
            $display("script write began before the matching id read ended");
            value_errs++;
         end
         if (release_time <= u_model.w_stop[n - 1]) begin
            $display("cam_released rose before the streaming write stopped");
            value_errs++;
         end
      end
   endtask

   task automatic check_hold();
      frames_at_rel = u_model.frames;
      for (int c = 0; c < HOLD_CYCLES; c++) begin
         @(posedge CLK_400K);
         #2;
         check_level("cam_released", cam_released, 1'b1);
      end
      check_count("frames after release", u_model.frames, frames_at_rel);
   endtask

   initial begin
      RESET_N      = 1'b0;
      clear        = 1'b0;
      nack_n       = '0;
      wrong_n      = '0;
      wrong_ids    = '0;
      seed         = 32'ha99c_a0b7;
      value_errs   = 0;
      timeout_errs = 0;
      release_time = 0;
      for (int row = 0; row < ROWS; row++) begin
         nack_n  = 4'(nack_tab[row]);
         wrong_n = 4'(wrong_tab[row]);
         for (int k = 0; k < 8; k++) begin
            rnd = reg_data_t'($random(seed));
            while (rnd == ID_EXPECTED) rnd = reg_data_t'($random(seed));
            wrong_ids[k * 8 +: 8] = rnd;
         end
         apply_reset();
         check_level("cam_released", cam_released, 1'b0);
         check_level("scl", scl, 1'b1);
         check_level("sda", sda, 1'b1);
         check_count("frames before start", u_model.frames, 0);
         wait_release(row);
         if (released_ok) begin
            check_byte("id slave byte", u_model.first_bytes[0], SENSOR_ADDR);
            check_addr("id pointer", {u_model.first_bytes[1], u_model.first_bytes[2]},
                       ID_POINTER);
            check_byte("id read slave byte", u_model.read_slave, SENSOR_ADDR | 8'h01);
            check_count("id reads", u_model.id_reads, reads_tab[row]);
            check_script();
            check_hold();
         end
      end
      $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
      if ((value_errs == 0) && (timeout_errs == 0)) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
hw/cam_cfg_pkg.sv
hw/i2c_pkg.sv
hw/sensor_script_rom.sv
hw/cfg_sequencer.sv
hw/cmd_fifo.sv
hw/i2c_master.sv
hw/camera_config_top.sv
tb/i2c_sensor_model.sv
tb/tb_camera_config.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_camera_config
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
